//--- tb.f
usb_serial_pkg.sv
send_fifo.sv
in_endpoint.sv
out_endpoint.sv
usb_serial_path.sv
tb_usb_serial.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_serial -f tb.f \
    && ./obj_dir/Vtb_usb_serial | tee /dev/stderr \
        | grep -x "Finished with no errors" > /dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- tb_usb_serial.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_serial;

    import usb_serial_pkg::*;

    logic       clk;
    logic       usb_rstn;
    logic [7:0] send_data;
    logic       send_valid;
    logic       send_ready;
    logic       in_token;
    logic       in_ack;
    logic       in_timeout;
    usb_beat_t  tx_beat;
    logic       tx_valid;
    usb_beat_t  rx_beat;
    logic       rx_valid;
    logic [7:0] recv_data;
    logic       recv_valid;

    logic [7:0] q[$];                                   // written but not yet acked
    int         pend;                                   // bytes awaiting ack / timeout
    logic       in_tgl;                                 // expected IN toggle
    logic       out_tgl;                                // expected OUT toggle
    logic       rx_fwd;                                 // current rx beat must be forwarded
    logic       fwd_prev;                               // last cycle's beat was forwarded
    logic [7:0] data_prev;
    int         recv_cnt;                               // recv_valid pulses from the DUT
    int         errs;
    int         tests;
    int         failed;
    int         seed;

    usb_serial_path dut0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .send_data  (send_data),
        .send_valid (send_valid),
        .send_ready (send_ready),
        .in_token   (in_token),
        .in_ack     (in_ack),
        .in_timeout (in_timeout),
        .tx_beat    (tx_beat),
        .tx_valid   (tx_valid),
        .rx_beat    (rx_beat),
        .rx_valid   (rx_valid),
        .recv_data  (recv_data),
        .recv_valid (recv_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                         // 100 ns period
    end

    initial begin
        #(100 * 200_000);                               // far beyond the longest test
        $display("simulation stopped by the watchdog");
        $display("Finished with errors");
        $finish;
    end

    //----------------------------------------------------------------------
    // reporting
    //----------------------------------------------------------------------

    task automatic value_error(input string name, input logic [7:0] got, input logic [7:0] exp);
        errs++;
        $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic plain_error(input string what);
        errs++;
        $display("%s at %0t", what, $time);
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        if (errs != mark) failed++;
        $display("test %0d %s: %0d errors", tests, name, errs - mark);
    endtask

    // OUT side scoreboard sampled mid cycle
    always @(negedge clk) begin
        if (usb_rstn) begin
            assert (recv_valid == fwd_prev)
                else value_error("recv_valid", 8'(recv_valid), 8'(fwd_prev));
            if (recv_valid) begin
                recv_cnt++;
            end
            if (fwd_prev) begin
                assert (recv_data == data_prev)         // 1 cycle behind its beat
                    else value_error("recv_data", recv_data, data_prev);
            end
            fwd_prev  = rx_valid & rx_fwd;
            data_prev = rx_beat.data;
        end
    end

    //----------------------------------------------------------------------
    // host and application models
    //----------------------------------------------------------------------

    task automatic write_bytes(input int n, output int taken);
        int stall;
        taken = 0;
        stall = 0;
        while (taken < n && stall < 4) begin            // full buffer never frees by itself
            @(posedge clk);
            #1;
            send_valid = 1'b1;
            send_data  = 8'($random(seed));
            @(negedge clk);
            if (send_ready) begin
                q.push_back(send_data);                 // taken at the coming edge
                taken++;
            end else begin
                stall++;
            end
        end
        @(posedge clk);
        #1 send_valid = 1'b0;
    endtask

    // one IN transaction with every beat checked against the model
    task automatic in_packet(output int n);
        int         lat;
        int         i;
        logic [7:0] pid;
        n   = (q.size() > MAX_PKT) ? MAX_PKT : q.size();
        pid = (n == 0) ? PID_NAK : (in_tgl ? PID_DATA1 : PID_DATA0);
        lat = 0;
        @(posedge clk);
        #1 in_token = 1'b1;
        @(posedge clk);
        #1 in_token = 1'b0;
        @(negedge clk);
        while (!tx_valid && lat < 8) begin              // first beat due right away
            @(negedge clk);
            lat++;
        end
        assert (lat == 0)
            else plain_error($sformatf("first beat not 1 cycle after token, %0d late", lat));
        if (tx_valid) begin
            assert (tx_beat.data == pid) else value_error("tx_beat.data", tx_beat.data, pid);
            assert (tx_beat.last == (n == 0))
                else value_error("tx_beat.last", 8'(tx_beat.last), 8'(n == 0));
            for (i = 0; i < n; i++) begin
                @(negedge clk);
                assert (tx_valid) else plain_error("gap inside an IN packet");
                assert (tx_beat.data == q[i])
                    else value_error("tx_beat.data", tx_beat.data, q[i]);
                assert (tx_beat.last == (i == n - 1))
                    else value_error("tx_beat.last", 8'(tx_beat.last), 8'(i == n - 1));
            end
            @(negedge clk);
            assert (!tx_valid) else plain_error("beat sent after the last one");
        end
        pend = n;
    endtask

    task automatic answer(input logic ack);
        int i;
        @(posedge clk);
        #1;
        in_ack     = ack;
        in_timeout = ~ack;
        @(posedge clk);
        #1;
        in_ack     = 1'b0;
        in_timeout = 1'b0;
        if (ack) begin
            for (i = 0; i < pend; i++) q.delete(0);     // acked bytes leave the model
            in_tgl = ~in_tgl;
        end
        pend = 0;                                       // timeout resends the same bytes
    endtask

    task automatic drain();
        int n;
        while (q.size() > 0) begin
            in_packet(n);
            answer(1'b1);
        end
    endtask

    task automatic out_packet(input logic [7:0] pid, input int n);
        logic fwd;
        int   i;
        fwd = (pid == (out_tgl ? PID_DATA1 : PID_DATA0)); // repeat pid is dropped
        for (i = 0; i <= n; i++) begin
            @(posedge clk);
            #1;
            if (i > 0 && ($random(seed) & 3) == 0) begin
                rx_valid = 1'b0;                        // idle cycle inside the packet
                @(posedge clk);
                #1;
            end
            rx_valid     = 1'b1;
            rx_beat.data = (i == 0) ? pid : 8'($random(seed));
            rx_beat.last = (i == n);
            rx_fwd       = fwd && (i > 0);
        end
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        rx_fwd   = 1'b0;
        if (fwd) out_tgl = ~out_tgl;
    endtask

    //----------------------------------------------------------------------
    // tests
    //----------------------------------------------------------------------

    initial begin
        int n;
        int taken;
        int mark;
        int rmark;
        int i;
        seed       = 19564;
        usb_rstn   = 1'b0;
        send_data  = 8'h00;
        send_valid = 1'b0;
        in_token   = 1'b0;
        in_ack     = 1'b0;
        in_timeout = 1'b0;
        rx_beat    = '0;
        rx_valid   = 1'b0;
        pend       = 0;
        in_tgl     = 1'b0;
        out_tgl    = 1'b0;
        rx_fwd     = 1'b0;
        fwd_prev   = 1'b0;
        data_prev  = 8'h00;
        recv_cnt   = 0;
        errs       = 0;
        tests      = 0;
        failed     = 0;
        repeat (2) @(posedge clk);
        #1 usb_rstn = 1'b1;

        mark = errs;
        @(negedge clk);
        assert (send_ready) else value_error("send_ready", 8'(send_ready), 8'h01);
        assert (!tx_valid) else value_error("tx_valid", 8'(tx_valid), 8'h00);
        assert (!recv_valid) else value_error("recv_valid", 8'(recv_valid), 8'h00);
        in_packet(n);                                   // empty buffer gives NAK
        end_test("reset and empty buffer", mark);

        mark = errs;
        write_bytes(40, taken);
        assert (taken == 40) else plain_error("buffer refused bytes while nearly empty");
        in_packet(n);
        answer(1'b1);
        in_packet(n);                                   // DATA1 with the remaining 8
        answer(1'b1);
        in_packet(n);
        end_test("packet splitting and toggle", mark);

        mark = errs;
        write_bytes(5, taken);
        in_packet(n);
        @(posedge clk);
        #1 in_token = 1'b1;                             // must be ignored while waiting
        @(posedge clk);
        #1 in_token = 1'b0;
        @(negedge clk);
        assert (!tx_valid) else plain_error("token while waiting for ack started a packet");
        answer(1'b0);
        in_packet(n);                                   // same pid and same bytes
        answer(1'b1);
        end_test("retry on timeout", mark);

        mark = errs;
        write_bytes(1100, taken);
        assert (taken == 1024)
            else plain_error($sformatf("buffer took %0d bytes instead of 1024", taken));
        @(negedge clk);
        assert (!send_ready) else value_error("send_ready", 8'(send_ready), 8'h00);
        in_packet(n);
        answer(1'b0);
        write_bytes(8, taken);
        assert (taken == 0) else plain_error("a timeout freed buffer space");
        in_packet(n);
        answer(1'b1);
        write_bytes(40, taken);
        assert (taken == 32)
            else plain_error($sformatf("ack freed %0d bytes instead of 32", taken));
        drain();
        end_test("full buffer", mark);

        mark  = errs;
        rmark = recv_cnt;
        out_packet(PID_DATA0, 6);
        out_packet(PID_DATA0, 6);                       // retransmission gets dropped
        out_packet(PID_DATA1, 4);
        repeat (2) @(negedge clk);
        assert (recv_cnt - rmark == 10)
            else plain_error($sformatf("%0d bytes forwarded instead of 10", recv_cnt - rmark));
        end_test("OUT path", mark);

        mark = errs;
        for (i = 0; i < 40; i++) begin
            write_bytes(int'($random(seed) & 32'h3f), taken);
            in_packet(n);
            if (n > 0) answer(($random(seed) & 3) != 0); // mostly ack
        end
        drain();
        in_packet(n);
        end_test("random traffic", mark);

        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed, errs);
        if (errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- usb_serial_path.sv
`timescale 1ns/1ps
`default_nettype none

module usb_serial_path (
    input  logic                      clk,
    input  logic                      usb_rstn,
    // application write side
    input  logic [7:0]                send_data,
    input  logic                      send_valid,
    output logic                      send_ready,
    // host side, IN endpoint
    input  logic                      in_token,
    input  logic                      in_ack,
    input  logic                      in_timeout,
    output usb_serial_pkg::usb_beat_t tx_beat,
    output logic                      tx_valid,
    // host side, OUT endpoint
    input  usb_serial_pkg::usb_beat_t rx_beat,
    input  logic                      rx_valid,
    output logic [7:0]                recv_data,
    output logic                      recv_valid
);

    import usb_serial_pkg::*;

    logic                rd_en;                       // buffer <-> IN endpoint
    logic                rd_commit;
    logic                rd_rewind;
    logic [7:0]          rd_data;
    logic [FIFO_ASIZE:0] rd_avail;

    //----------------------------------------------------------------------
    // device to host
    //----------------------------------------------------------------------

    send_fifo #(
        .ASIZE      (FIFO_ASIZE)
    ) send_fifo0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .send_data  (send_data),
        .send_valid (send_valid),
        .send_ready (send_ready),
        .rd_en      (rd_en),
        .rd_commit  (rd_commit),
        .rd_rewind  (rd_rewind),
        .rd_data    (rd_data),
        .rd_avail   (rd_avail)
    );

    in_endpoint in_endpoint0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .in_token   (in_token),
        .in_ack     (in_ack),
        .in_timeout (in_timeout),
        .tx_beat    (tx_beat),
        .tx_valid   (tx_valid),
        .rd_en      (rd_en),
        .rd_commit  (rd_commit),
        .rd_rewind  (rd_rewind),
        .rd_data    (rd_data),
        .rd_avail   (rd_avail)
    );

    //----------------------------------------------------------------------
    // host to device
    //----------------------------------------------------------------------

    out_endpoint out_endpoint0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .rx_beat    (rx_beat),
        .rx_valid   (rx_valid),
        .recv_data  (recv_data),
        .recv_valid (recv_valid)
    );

endmodule

`default_nettype wire

//--- out_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module out_endpoint (
    input  logic                      clk,
    input  logic                      usb_rstn,
    input  usb_serial_pkg::usb_beat_t rx_beat,
    input  logic                      rx_valid,
    output logic [7:0]                recv_data,
    output logic                      recv_valid
);

    import usb_serial_pkg::*;

    logic in_pkt;                                     // past the pid beat
    logic accept;                                     // current packet is new data
    logic exp_tgl;                                    // expected toggle, 0 = DATA0
    logic pid_ok;                                     // pid matches the toggle

    assign pid_ok = (rx_beat.data == (exp_tgl ? PID_DATA1 : PID_DATA0));

    //----------------------------------------------------------------------
    // packet tracking and duplicate drop
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            in_pkt     <= 1'b0;
            accept     <= 1'b0;
            exp_tgl    <= 1'b0;
            recv_valid <= 1'b0;
        end else begin
            recv_valid <= 1'b0;                       // one pulse per byte
            if (rx_valid) begin
                if (!in_pkt) begin
                    accept <= pid_ok;                 // repeat pid = retransmit
                    in_pkt <= ~rx_beat.last;
                    if (rx_beat.last && pid_ok) begin
                        exp_tgl <= ~exp_tgl;          // zero length packet
                    end
                end else begin
                    recv_valid <= accept;
                    if (rx_beat.last) begin
                        in_pkt <= 1'b0;               // next beat is a pid
                        if (accept) begin
                            exp_tgl <= ~exp_tgl;
                        end
                    end
                end
            end
        end
    end

    // payload byte, 1 cycle behind its beat
    always_ff @(posedge clk) begin
        if (rx_valid && in_pkt && accept) begin
            recv_data <= rx_beat.data;
        end
    end

endmodule

`default_nettype wire

//--- in_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module in_endpoint (
    input  logic                                clk,
    input  logic                                usb_rstn,
    // host side
    input  logic                                in_token,     // host asks for data
    input  logic                                in_ack,       // host got the packet
    input  logic                                in_timeout,   // no handshake came back
    output usb_serial_pkg::usb_beat_t           tx_beat,
    output logic                                tx_valid,
    // send buffer side
    output logic                                rd_en,
    output logic                                rd_commit,
    output logic                                rd_rewind,
    input  logic [7:0]                          rd_data,
    input  logic [usb_serial_pkg::FIFO_ASIZE:0] rd_avail
);

    import usb_serial_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                                              // waiting for a token
        ST_PID,                                               // pid or nak beat on the bus
        ST_DATA,                                              // payload beats
        ST_WAIT                                               // waiting for ack / timeout
    } state_t;

    state_t              state;
    logic                tgl;                                 // data toggle, 0 = DATA0
    logic [FIFO_ASIZE:0] cnt;                                 // beats left incl. current
    logic [FIFO_ASIZE:0] pkt_len;                             // length if token now
    logic                nak;                                 // empty packet -> nak
    logic                last_beat;                           // final payload beat

    //----------------------------------------------------------------------
    // packet length and beat flags
    //----------------------------------------------------------------------

    assign pkt_len   = (rd_avail > MAX_PKT) ? (FIFO_ASIZE+1)'(MAX_PKT) : rd_avail;
    assign nak       = (cnt == '0);                           // nothing latched at token
    assign last_beat = (cnt == (FIFO_ASIZE+1)'(1));

    //----------------------------------------------------------------------
    // outputs, decoded from state
    //----------------------------------------------------------------------

    always_comb begin
        tx_valid     = 1'b0;
        tx_beat.data = rd_data;                               // payload straight from ram
        tx_beat.last = 1'b0;
        rd_en        = 1'b0;
        rd_commit    = 1'b0;
        rd_rewind    = 1'b0;
        case (state)
            ST_PID: begin
                tx_valid = 1'b1;
                if (nak) begin
                    tx_beat.data = PID_NAK;
                    tx_beat.last = 1'b1;                      // nak is a one beat packet
                end else begin
                    tx_beat.data = tgl ? PID_DATA1 : PID_DATA0;
                    rd_en        = 1'b1;                      // prefetch first byte
                end
            end
            ST_DATA: begin
                tx_valid     = 1'b1;
                tx_beat.last = last_beat;
                rd_en        = ~last_beat;                    // fetch for next cycle
            end
            ST_WAIT: begin
                rd_commit = in_ack;                           // ack wins if both
                rd_rewind = in_timeout & ~in_ack;             // same packet resent later
            end
            default: begin
            end
        endcase
    end

    //----------------------------------------------------------------------
    // fsm
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state <= ST_IDLE;
            tgl   <= 1'b0;                                    // start at DATA0
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_token) begin
                        cnt   <= pkt_len;                     // length fixed at token
                        state <= ST_PID;
                    end
                end
                ST_PID: begin
                    state <= nak ? ST_IDLE : ST_DATA;         // nak needs no answer
                end
                ST_DATA: begin
                    cnt <= cnt - 1'b1;
                    if (last_beat) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (in_ack) begin
                        tgl   <= ~tgl;                        // next packet, other pid
                        state <= ST_IDLE;
                    end else if (in_timeout) begin
                        state <= ST_IDLE;                     // toggle kept for retry
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- send_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module send_fifo #(
    parameter int ASIZE = usb_serial_pkg::FIFO_ASIZE    // log2 of buffer depth
) (
    input  logic           clk,
    input  logic           usb_rstn,
    // application write side
    input  logic [7:0]     send_data,
    input  logic           send_valid,
    output logic           send_ready,
    // endpoint read side
    input  logic           rd_en,                       // advance speculative ptr
    input  logic           rd_commit,                   // host acked, keep the read
    input  logic           rd_rewind,                   // no handshake, read again
    output logic [7:0]     rd_data,                     // valid 1 cycle after rd_en
    output logic [ASIZE:0] rd_avail                     // bytes past speculative ptr
);

    //----------------------------------------------------------------------
    // storage and pointers
    //----------------------------------------------------------------------

    logic [7:0]     mem [1 << ASIZE];                   // maps to block ram
    logic [ASIZE:0] wptr;                               // write ptr, msb = wrap bit
    logic [ASIZE:0] cptr;                               // committed read ptr
    logic [ASIZE:0] sptr;                               // speculative read ptr
    logic [ASIZE:0] used;                               // held bytes incl. unacked
    logic           wr_fire;                            // byte taken this cycle

    assign wr_fire    = send_valid & send_ready;
    assign used       = wptr - cptr;                    // sent but unacked still counts
    assign send_ready = ~used[ASIZE];                   // msb only set when full
    assign rd_avail   = wptr - sptr;                    // what the endpoint may still read

    //----------------------------------------------------------------------
    // write side
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wptr <= '0;
        end else if (wr_fire) begin
            wptr <= wptr + 1'b1;                        // wraps through the msb
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wptr[ASIZE-1:0]] <= send_data;
        end
    end

    //----------------------------------------------------------------------
    // read side
    //----------------------------------------------------------------------

    // speculative ptr runs ahead while a packet goes out
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            sptr <= '0;
        end else if (rd_rewind) begin
            sptr <= cptr;                               // back to last acked byte
        end else if (rd_en) begin
            sptr <= sptr + 1'b1;
        end
    end

    // committed ptr only moves once the host has the packet
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            cptr <= '0;
        end else if (rd_commit) begin
            cptr <= sptr;                               // frees the acked bytes
        end
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[sptr[ASIZE-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- usb_serial_pkg.sv
`default_nettype none

package usb_serial_pkg;

    //----------------------------------------------------------------------
    // sizes
    //----------------------------------------------------------------------

    localparam int FIFO_ASIZE = 10;           // send buffer holds 2**10 bytes
    localparam int MAX_PKT    = 32;           // data bytes per IN packet, max

    //----------------------------------------------------------------------
    // packet ids, as sent on the wire
    //----------------------------------------------------------------------

    localparam logic [7:0] PID_DATA0 = 8'hC3; // even data packet
    localparam logic [7:0] PID_DATA1 = 8'h4B; // odd data packet
    localparam logic [7:0] PID_NAK   = 8'h5A; // handshake, nothing to send

    //----------------------------------------------------------------------
    // host side byte stream
    //----------------------------------------------------------------------

    // one byte of a packet; the first beat of every packet is its pid
    typedef struct packed {
        logic [7:0] data;                     // pid or payload byte
        logic       last;                     // final beat of the packet
    } usb_beat_t;

endpackage

`default_nettype wire
